/* rtl/wf_pkg.sv */
//################################################
// shared widths, stage counts and NCO table for the waterfall path
// exponents above MAX_LOG2_DECIM are clamped by the CIC
//################################################
`default_nettype none

package wf_pkg;

    localparam int IN_WIDTH    = 14;
    localparam int MIX_WIDTH   = 18;
    localparam int CIC1_WIDTH  = 20;
    localparam int OUT_WIDTH   = 16;
    localparam int PHASE_WIDTH = 32;

    // 256 steps per circle, one quarter stored
    localparam int LUT_ADDR  = 6;
    localparam int LUT_WIDTH = 16;

    // keeps the top MIX_WIDTH bits of the sample times table product
    localparam int MIX_SHIFT = IN_WIDTH + LUT_WIDTH - MIX_WIDTH - 1;

    localparam int CIC1_STAGES = 3;
    localparam int CIC2_STAGES = 4;

    localparam int DECIM_BITS = 3;
    localparam logic [DECIM_BITS-1:0] MAX_LOG2_DECIM = 3'd4;

    localparam int BUF_DEPTH = 256;
    localparam int BUF_ADDR  = 8;

    // round(32767 * cos(2*pi*i/256)) for i = 0 .. 63
    localparam logic signed [LUT_WIDTH-1:0] COS_TABLE [2**LUT_ADDR] = '{
        32767, 32757, 32728, 32678, 32609, 32521, 32412, 32285,
        32137, 31971, 31785, 31580, 31356, 31113, 30852, 30571,
        30273, 29956, 29621, 29268, 28898, 28510, 28105, 27683,
        27245, 26790, 26319, 25832, 25329, 24811, 24279, 23731,
        23170, 22594, 22005, 21403, 20787, 20159, 19519, 18868,
        18204, 17530, 16846, 16151, 15446, 14732, 14010, 13279,
        12539, 11793, 11039, 10278,  9512,  8739,  7962,  7179,
         6393,  5602,  4808,  4011,  3212,  2410,  1608,   804
    };

    typedef logic signed [MIX_WIDTH-1:0]  mix_t;
    typedef logic signed [CIC1_WIDTH-1:0] cic1_t;
    typedef logic signed [OUT_WIDTH-1:0]  out_t;

endpackage

`default_nettype wire

/* rtl/wf_nco_mixer.sv */
//################################################
// output appears two cycles after its ADC sample
// products are truncated, not rounded
//################################################
`default_nettype none

module wf_nco_mixer (
    input  wire logic                                 adc_clk,
    input  wire logic                                 reset_i,
    input  wire logic                                 set_freq_i,
    input  wire logic [31:0]                          cfg_word_i,
    input  wire logic signed [wf_pkg::IN_WIDTH-1:0]   adc_data_i,
    output wf_pkg::mix_t                              mix_i_o,
    output wf_pkg::mix_t                              mix_q_o
);

    logic [wf_pkg::PHASE_WIDTH-1:0]         phase_inc;
    logic [wf_pkg::PHASE_WIDTH-1:0]         phase_acc;
    logic [wf_pkg::LUT_ADDR+1:0]            phase_top;
    logic signed [wf_pkg::IN_WIDTH-1:0]     adc_q;
    logic signed [wf_pkg::LUT_WIDTH-1:0]    cos_val;
    logic signed [wf_pkg::LUT_WIDTH-1:0]    nsin_val;
    logic signed [wf_pkg::IN_WIDTH+wf_pkg::LUT_WIDTH-1:0] prod_i;
    logic signed [wf_pkg::IN_WIDTH+wf_pkg::LUT_WIDTH-1:0] prod_q;

    // full-circle cosine from the quarter table
    // quadrants 1 and 3 mirror the index, 1 and 2 flip the sign
    function automatic logic signed [wf_pkg::LUT_WIDTH-1:0] lut_cos(
        input logic [wf_pkg::LUT_ADDR+1:0] p
    );
        logic [wf_pkg::LUT_ADDR-1:0]       idx;
        logic [wf_pkg::LUT_ADDR:0]         mir;
        logic signed [wf_pkg::LUT_WIDTH-1:0] val;
        idx = p[wf_pkg::LUT_ADDR-1:0];
        mir = {1'b1, {wf_pkg::LUT_ADDR{1'b0}}} - {1'b0, idx};
        if (!p[wf_pkg::LUT_ADDR])
            val = wf_pkg::COS_TABLE[idx];
        // mirrored index of 64 lands on the zero crossing
        else if (mir[wf_pkg::LUT_ADDR])
            val = '0;
        else
            val = wf_pkg::COS_TABLE[mir[wf_pkg::LUT_ADDR-1:0]];
        return (p[wf_pkg::LUT_ADDR+1] ^ p[wf_pkg::LUT_ADDR]) ? -val : val;
    endfunction

    always_ff @(posedge adc_clk)
    begin
        if (reset_i)
        begin
            phase_inc <= '0;
            phase_acc <= '0;
        end
        else
        begin
            if (set_freq_i)
                phase_inc <= cfg_word_i;
            phase_acc <= phase_acc + phase_inc;
        end
    end

    assign phase_top = phase_acc[wf_pkg::PHASE_WIDTH-1 -: wf_pkg::LUT_ADDR+2];

    // -sin(x) is cos(x + quarter turn)
    assign cos_val  = lut_cos(phase_top);
    assign nsin_val = lut_cos(phase_top + 8'd64);

    assign prod_i = adc_q * cos_val;
    assign prod_q = adc_q * nsin_val;

    always_ff @(posedge adc_clk)
    begin
        adc_q   <= adc_data_i;
        mix_i_o <= prod_i[wf_pkg::MIX_SHIFT +: wf_pkg::MIX_WIDTH];
        mix_q_o <= prod_q[wf_pkg::MIX_SHIFT +: wf_pkg::MIX_WIDTH];
    end

endmodule

`default_nettype wire

/* rtl/wf_cic_decim.sv */
//################################################
// power-of-two rate only, output one cycle after the last input
// gain is removed by an exact shift of STAGES*k
//################################################
`default_nettype none

module wf_cic_decim #(
    parameter type in_t   = wf_pkg::mix_t,
    parameter type out_t  = wf_pkg::cic1_t,
    parameter int  STAGES = 3
) (
    input  wire logic                          adc_clk,
    input  wire logic                          reset_i,
    input  wire logic                          clear_i,
    input  wire logic                          set_decim_i,
    input  wire logic [wf_pkg::DECIM_BITS-1:0] log2_decim_i,
    input  wire logic                          in_stb_i,
    input  wire in_t                           in_data_i,
    output logic                               out_stb_o,
    output out_t                               out_data_o
);

    localparam int IN_W  = $bits(in_t);
    localparam int OUT_W = $bits(out_t);
    localparam int ACC_W = IN_W + STAGES * wf_pkg::MAX_LOG2_DECIM;
    localparam int UP    = (OUT_W > IN_W) ? OUT_W - IN_W : 0;
    localparam int DN    = (IN_W > OUT_W) ? IN_W - OUT_W : 0;

    logic [wf_pkg::DECIM_BITS-1:0]     log2_q;
    logic [wf_pkg::MAX_LOG2_DECIM-1:0] cnt;
    logic [wf_pkg::MAX_LOG2_DECIM-1:0] cnt_last;
    logic signed [ACC_W-1:0] in_ext;
    logic signed [ACC_W-1:0] integ     [STAGES];
    logic signed [ACC_W-1:0] integ_nxt [STAGES];
    logic signed [ACC_W-1:0] comb_dly  [STAGES];
    logic signed [ACC_W-1:0] comb_val  [STAGES+1];
    logic signed [ACC_W-1:0] norm;
    out_t                    out_nxt;

    assign in_ext   = in_data_i;
    assign cnt_last = ~({wf_pkg::MAX_LOG2_DECIM{1'b1}} << log2_q);

    // integrators see the current input so the comb can use it at once
    always_comb
    begin
        integ_nxt[0] = integ[0] + in_ext;
        for (int s = 1; s < STAGES; s++)
            integ_nxt[s] = integ[s] + integ_nxt[s-1];
        comb_val[0] = integ_nxt[STAGES-1];
        for (int s = 0; s < STAGES; s++)
            comb_val[s+1] = comb_val[s] - comb_dly[s];
        norm    = comb_val[STAGES] >>> (STAGES * log2_q);
        out_nxt = out_t'((norm <<< UP) >>> DN);
    end

    always_ff @(posedge adc_clk)
    begin
        if (reset_i)
            log2_q <= '0;
        else if (set_decim_i)
        begin
            if (log2_decim_i > wf_pkg::MAX_LOG2_DECIM)
                log2_q <= wf_pkg::MAX_LOG2_DECIM;
            else
                log2_q <= log2_decim_i;
        end
    end

    always_ff @(posedge adc_clk)
    begin
        if (reset_i || clear_i)
        begin
            cnt       <= '0;
            out_stb_o <= 1'b0;
            for (int s = 0; s < STAGES; s++)
            begin
                integ[s]    <= '0;
                comb_dly[s] <= '0;
            end
        end
        else
        begin
            out_stb_o <= 1'b0;
            if (in_stb_i)
            begin
                integ <= integ_nxt;
                if (cnt == cnt_last)
                begin
                    cnt       <= '0;
                    out_stb_o <= 1'b1;
                    for (int s = 0; s < STAGES; s++)
                        comb_dly[s] <= comb_val[s];
                end
                else
                    cnt <= cnt + 1'b1;
            end
        end
    end

    // held between strobes
    always_ff @(posedge adc_clk)
    begin
        if (in_stb_i && (cnt == cnt_last))
            out_data_o <= out_nxt;
    end

endmodule

`default_nettype wire

/* rtl/wf_sample_buf.sv */
//################################################
// no full flag, a wrapped write overwrites the oldest pair
// read I first, then Q which advances the read pointer
//################################################
`default_nettype none

module wf_sample_buf (
    input  wire logic                         adc_clk,
    input  wire logic                         reset_i,
    input  wire logic                         clear_i,
    input  wire logic                         wr_stb_i,
    input  wire wf_pkg::out_t                 wr_i_i,
    input  wire wf_pkg::out_t                 wr_q_i,
    input  wire logic                         rd_i_i,
    input  wire logic                         rd_q_i,
    output logic                              rd_o,
    output logic [wf_pkg::OUT_WIDTH-1:0]      dout_o
);

    wf_pkg::out_t mem_i [wf_pkg::BUF_DEPTH];
    wf_pkg::out_t mem_q [wf_pkg::BUF_DEPTH];

    logic [wf_pkg::BUF_ADDR-1:0] wr_ptr;
    logic [wf_pkg::BUF_ADDR-1:0] rd_ptr;

    always_ff @(posedge adc_clk)
    begin
        if (wr_stb_i)
        begin
            mem_i[wr_ptr] <= wr_i_i;
            mem_q[wr_ptr] <= wr_q_i;
        end
    end

    always_ff @(posedge adc_clk)
    begin
        if (reset_i || clear_i)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end
        else
        begin
            if (wr_stb_i)
                wr_ptr <= wr_ptr + 1'b1;
            if (rd_q_i)
                rd_ptr <= rd_ptr + 1'b1;
        end
    end

    always_ff @(posedge adc_clk)
    begin
        if (reset_i)
            rd_o <= 1'b0;
        else
            rd_o <= rd_i_i || rd_q_i;
    end

    // registered read, same-cycle write to the address returns old data
    always_ff @(posedge adc_clk)
    begin
        if (rd_i_i)
            dout_o <= mem_i[rd_ptr];
        else if (rd_q_i)
            dout_o <= mem_q[rd_ptr];
    end

endmodule

`default_nettype wire

/* rtl/waterfall.sv */
//################################################
// single clock, host strobes must be synchronous to adc_clk
// follow every decimation change with rst_sampler_i
//################################################
`default_nettype none

module waterfall (
    input  wire logic                               adc_clk,
    input  wire logic                               reset_i,
    input  wire logic signed [wf_pkg::IN_WIDTH-1:0] adc_data_i,
    input  wire logic [31:0]                        cfg_word_i,
    input  wire logic                               set_freq_i,
    input  wire logic                               set_decim_i,
    input  wire logic                               rst_sampler_i,
    input  wire logic                               rd_i_i,
    input  wire logic                               rd_q_i,
    output logic                                    wf_rd_o,
    output logic [wf_pkg::OUT_WIDTH-1:0]            wf_dout_o
);

    wf_pkg::mix_t  mix_i;
    wf_pkg::mix_t  mix_q;
    wf_pkg::cic1_t cic1_i;
    wf_pkg::cic1_t cic1_q;
    wf_pkg::out_t  cic2_i;
    wf_pkg::out_t  cic2_q;
    logic          cic1_stb;
    logic          cic2_stb;

    wf_nco_mixer u_mixer (
        .adc_clk    (adc_clk),
        .reset_i    (reset_i),
        .set_freq_i (set_freq_i),
        .cfg_word_i (cfg_word_i),
        .adc_data_i (adc_data_i),
        .mix_i_o    (mix_i),
        .mix_q_o    (mix_q)
    );

    // stage 1 runs on every mixer sample, Q strobe matches I
    wf_cic_decim #(
        .in_t   (wf_pkg::mix_t),
        .out_t  (wf_pkg::cic1_t),
        .STAGES (wf_pkg::CIC1_STAGES)
    ) u_cic1_i (
        .adc_clk (adc_clk), .reset_i (reset_i), .clear_i (rst_sampler_i),
        .set_decim_i (set_decim_i), .log2_decim_i (cfg_word_i[2:0]),
        .in_stb_i (1'b1), .in_data_i (mix_i),
        .out_stb_o (cic1_stb), .out_data_o (cic1_i)
    );

    wf_cic_decim #(
        .in_t   (wf_pkg::mix_t),
        .out_t  (wf_pkg::cic1_t),
        .STAGES (wf_pkg::CIC1_STAGES)
    ) u_cic1_q (
        .adc_clk (adc_clk), .reset_i (reset_i), .clear_i (rst_sampler_i),
        .set_decim_i (set_decim_i), .log2_decim_i (cfg_word_i[2:0]),
        .in_stb_i (1'b1), .in_data_i (mix_q),
        .out_stb_o (), .out_data_o (cic1_q)
    );

    wf_cic_decim #(
        .in_t   (wf_pkg::cic1_t),
        .out_t  (wf_pkg::out_t),
        .STAGES (wf_pkg::CIC2_STAGES)
    ) u_cic2_i (
        .adc_clk (adc_clk), .reset_i (reset_i), .clear_i (rst_sampler_i),
        .set_decim_i (set_decim_i), .log2_decim_i (cfg_word_i[10:8]),
        .in_stb_i (cic1_stb), .in_data_i (cic1_i),
        .out_stb_o (cic2_stb), .out_data_o (cic2_i)
    );

    wf_cic_decim #(
        .in_t   (wf_pkg::cic1_t),
        .out_t  (wf_pkg::out_t),
        .STAGES (wf_pkg::CIC2_STAGES)
    ) u_cic2_q (
        .adc_clk (adc_clk), .reset_i (reset_i), .clear_i (rst_sampler_i),
        .set_decim_i (set_decim_i), .log2_decim_i (cfg_word_i[10:8]),
        .in_stb_i (cic1_stb), .in_data_i (cic1_q),
        .out_stb_o (), .out_data_o (cic2_q)
    );

    wf_sample_buf u_buf (
        .adc_clk  (adc_clk),
        .reset_i  (reset_i),
        .clear_i  (rst_sampler_i),
        .wr_stb_i (cic2_stb),
        .wr_i_i   (cic2_i),
        .wr_q_i   (cic2_q),
        .rd_i_i   (rd_i_i),
        .rd_q_i   (rd_q_i),
        .rd_o     (wf_rd_o),
        .dout_o   (wf_dout_o)
    );

endmodule

`default_nettype wire

/* sim/waterfall_sva.sv */
//################################################
// EXACT=1 requires a pulse after every trigger
//################################################
`default_nettype none

module waterfall_sva #(
    parameter bit EXACT = 1'b0
) (
    input wire logic clk_i,
    input wire logic reset_i,
    input wire logic trig_i,
    input wire logic pulse_i
);

    timeunit 1ns;
    timeprecision 1ps;

    // a pulse is always owed to a trigger one cycle earlier
    assert property (@(posedge clk_i) disable iff (reset_i) pulse_i |-> $past(trig_i))
        else $error("pulse without a trigger in the previous cycle");

    assert property (@(posedge clk_i) disable iff (reset_i) EXACT && trig_i |=> pulse_i)
        else $error("trigger not followed by a pulse one cycle later");

    assert property (@(posedge clk_i) reset_i |=> !pulse_i)
        else $error("pulse output high after reset");

endmodule

bind wf_sample_buf waterfall_sva #(.EXACT(1'b1)) u_buf_sva (
    .clk_i   (adc_clk),
    .reset_i (reset_i),
    .trig_i  (rd_i_i || rd_q_i),
    .pulse_i (rd_o)
);

bind wf_cic_decim waterfall_sva #(.EXACT(1'b0)) u_cic_sva (
    .clk_i   (adc_clk),
    .reset_i (reset_i),
    .trig_i  (in_stb_i),
    .pulse_i (out_stb_o)
);

`default_nettype wire

/* sim/tb_waterfall.sv */
//################################################
// bit-exact reference of mixer, both CIC stages and the buffer
// reads only pairs the model counts as written
//################################################
`default_nettype none

module tb_waterfall;

    timeunit 1ns;
    timeprecision 1ps;

    localparam logic [31:0] SEED = 32'ha05b_9861;
    // expected cycles per test, reads cost about four cycles a pair
    localparam int TEST_CYCLES = 100*4 + 160*4 + 40*8 + 40*8 + 6*256 + 60*4 + 7*24 + 16;
    localparam int CYCLE_LIMIT = TEST_CYCLES * 3 / 2;

    logic                                adc_clk = 1'b0;
    logic                                reset_i;
    logic signed [wf_pkg::IN_WIDTH-1:0]  adc_data_i;
    logic [31:0]                         cfg_word_i;
    logic                                set_freq_i;
    logic                                set_decim_i;
    logic                                rst_sampler_i;
    logic                                rd_i_i;
    logic                                rd_q_i;
    logic                                wf_rd_o;
    logic [wf_pkg::OUT_WIDTH-1:0]        wf_dout_o;

    // model state, instances 0/1 are stage-1 I/Q, 2/3 are stage-2 I/Q
    longint      m_integ [4][4];
    longint      m_comb  [4][4];
    int          m_cnt   [4];
    longint      m_cout  [4];
    bit          m_stb1 = 1'b0;
    bit          m_stb2 = 1'b0;
    longint      m_adc_q = 0;
    longint      m_mix_i = 0;
    longint      m_mix_q = 0;
    logic [31:0] m_acc = '0;
    logic [31:0] m_inc = '0;
    int          m_log_a = 0;
    int          m_log_b = 0;

    logic [15:0] exp_i [$];
    logic [15:0] exp_q [$];
    int          rd_idx = 0;
    bit          rd_pend = 1'b0;
    logic [15:0] rd_word;
    int          errors = 0;
    int          cycles = 0;

    waterfall dut (
        .adc_clk       (adc_clk),
        .reset_i       (reset_i),
        .adc_data_i    (adc_data_i),
        .cfg_word_i    (cfg_word_i),
        .set_freq_i    (set_freq_i),
        .set_decim_i   (set_decim_i),
        .rst_sampler_i (rst_sampler_i),
        .rd_i_i        (rd_i_i),
        .rd_q_i        (rd_q_i),
        .wf_rd_o       (wf_rd_o),
        .wf_dout_o     (wf_dout_o)
    );

    always #50 adc_clk = ~adc_clk;

    task automatic check_value(input logic [63:0] got, input logic [63:0] exp,
                               input string what);
        if (got !== exp)
        begin
            errors++;
            $display("Mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
            $display("tests failed");
            $fatal(1);
        end
    endtask

    // sign-extend the low w bits, models a w-bit register that wraps
    function automatic longint wrap_bits(input longint v, input int w);
        return (v <<< (64 - w)) >>> (64 - w);
    endfunction

    // cosine of p * 2pi/256 built from the quarter table
    function automatic longint table_cos(input logic [7:0] p);
        int idx;
        longint mir;
        idx = p[5:0];
        mir = (idx == 0) ? 0 : longint'(wf_pkg::COS_TABLE[64 - idx]);
        case (p[7:6])
            2'd0: return longint'(wf_pkg::COS_TABLE[idx]);
            2'd1: return -mir;
            2'd2: return -longint'(wf_pkg::COS_TABLE[idx]);
            default: return mir;
        endcase
    endfunction

    function automatic longint mix_value(input longint sample, input longint coef);
        return wrap_bits((sample * coef) >>> wf_pkg::MIX_SHIFT, wf_pkg::MIX_WIDTH);
    endfunction

    function automatic void cic_clear(input int n);
        for (int s = 0; s < 4; s++)
        begin
            m_integ[n][s] = 0;
            m_comb[n][s] = 0;
        end
        m_cnt[n] = 0;
    endfunction

    // one accepted input, returns 1 when a decimated output is produced
    function automatic bit cic_step(input int n, input int stages, input int in_w,
                                    input int out_w, input int k, input longint x);
        int     aw;
        longint cv;
        longint tmp;
        longint norm;
        aw = in_w + stages * int'(wf_pkg::MAX_LOG2_DECIM);
        m_integ[n][0] = wrap_bits(m_integ[n][0] + x, aw);
        for (int s = 1; s < stages; s++)
            m_integ[n][s] = wrap_bits(m_integ[n][s] + m_integ[n][s-1], aw);
        if (m_cnt[n] != (1 << k) - 1)
        begin
            m_cnt[n]++;
            return 1'b0;
        end
        m_cnt[n] = 0;
        cv = m_integ[n][stages-1];
        for (int s = 0; s < stages; s++)
        begin
            tmp = wrap_bits(cv - m_comb[n][s], aw);
            m_comb[n][s] = cv;
            cv = tmp;
        end
        norm = cv >>> (stages * k);
        if (out_w > in_w)
            norm = norm <<< (out_w - in_w);
        else
            norm = norm >>> (in_w - out_w);
        m_cout[n] = wrap_bits(norm, out_w);
        return 1'b1;
    endfunction

    // ADC samples, one per clock from the fixed seed
    initial
    begin
        void'($urandom(SEED));
        forever
        begin
            @(posedge adc_clk);
            adc_data_i <= wf_pkg::IN_WIDTH'($urandom);
        end
    end

    // reference model, advanced with the DUT's pre-edge inputs
    always @(posedge adc_clk)
    begin
        bit clr;
        bit hit;
        clr = reset_i || rst_sampler_i;
        if (!reset_i)
            check_value(dut.cic2_stb, m_stb2, "buffer write strobe");
        if (clr)
        begin
            exp_i.delete();
            exp_q.delete();
        end
        else if (m_stb2)
        begin
            exp_i.push_back(16'(m_cout[2]));
            exp_q.push_back(16'(m_cout[3]));
        end
        if (clr)
        begin
            cic_clear(2);
            cic_clear(3);
            m_stb2 = 1'b0;
        end
        else if (m_stb1)
        begin
            hit = cic_step(2, wf_pkg::CIC2_STAGES, wf_pkg::CIC1_WIDTH, wf_pkg::OUT_WIDTH,
                           m_log_b, m_cout[0]);
            void'(cic_step(3, wf_pkg::CIC2_STAGES, wf_pkg::CIC1_WIDTH, wf_pkg::OUT_WIDTH,
                           m_log_b, m_cout[1]));
            m_stb2 = hit;
        end
        else
            m_stb2 = 1'b0;
        if (clr)
        begin
            cic_clear(0);
            cic_clear(1);
            m_stb1 = 1'b0;
        end
        else
        begin
            m_stb1 = cic_step(0, wf_pkg::CIC1_STAGES, wf_pkg::MIX_WIDTH, wf_pkg::CIC1_WIDTH,
                              m_log_a, m_mix_i);
            void'(cic_step(1, wf_pkg::CIC1_STAGES, wf_pkg::MIX_WIDTH, wf_pkg::CIC1_WIDTH,
                           m_log_a, m_mix_q));
        end
        m_mix_i = mix_value(m_adc_q, table_cos(m_acc[31:24]));
        m_mix_q = mix_value(m_adc_q, table_cos(m_acc[31:24] + 8'd64));
        m_adc_q = adc_data_i;
        if (reset_i)
        begin
            m_acc = '0;
            m_inc = '0;
            m_log_a = 0;
            m_log_b = 0;
        end
        else
        begin
            m_acc = m_acc + m_inc;
            if (set_freq_i)
                m_inc = cfg_word_i;
            if (set_decim_i)
            begin
                m_log_a = cfg_word_i[2:0];
                m_log_b = cfg_word_i[10:8];
            end
        end
    end

    // compare process, each strobe expects one read cycle right after it
    always @(posedge adc_clk)
    begin
        if (!reset_i)
        begin
            check_value(wf_rd_o, rd_pend, "wf_rd_o");
            if (rd_pend)
                check_value(wf_dout_o, rd_word, "wf_dout_o");
        end
        rd_pend = rd_i_i || rd_q_i;
        if (rd_i_i)
            rd_word = exp_i[rd_idx];
        if (rd_q_i)
        begin
            rd_word = exp_q[rd_idx];
            rd_idx++;
        end
        if (reset_i || rst_sampler_i)
            rd_idx = 0;
    end

    always @(posedge adc_clk)
    begin
        cycles++;
        if (cycles >= CYCLE_LIMIT)
        begin
            $display("timeout after %0d cycles, the DUT stopped producing samples", cycles);
            $display("tests failed");
            $fatal(1);
        end
    end

    task automatic restart_sampler();
        @(posedge adc_clk);
        rst_sampler_i <= 1'b1;
        @(posedge adc_clk);
        rst_sampler_i <= 1'b0;
    endtask

    task automatic configure(input logic [31:0] freq, input int k1, input int k2);
        @(posedge adc_clk);
        cfg_word_i <= freq;
        set_freq_i <= 1'b1;
        @(posedge adc_clk);
        set_freq_i  <= 1'b0;
        cfg_word_i  <= {21'd0, 3'(k2), 5'd0, 3'(k1)};
        set_decim_i <= 1'b1;
        @(posedge adc_clk);
        set_decim_i <= 1'b0;
        restart_sampler();
    endtask

    // I then Q for each pair once the model says it is in the buffer
    task automatic read_pairs(input int n);
        for (int i = 0; i < n; i++)
        begin
            do
                @(negedge adc_clk);
            while (exp_i.size() <= i);
            @(posedge adc_clk);
            rd_i_i <= 1'b1;
            @(posedge adc_clk);
            rd_i_i <= 1'b0;
            rd_q_i <= 1'b1;
            @(posedge adc_clk);
            rd_q_i <= 1'b0;
        end
        repeat (2) @(posedge adc_clk);
    endtask

    initial
    begin
        reset_i       = 1'b1;
        adc_data_i    = '0;
        cfg_word_i    = '0;
        set_freq_i    = 1'b0;
        set_decim_i   = 1'b0;
        rst_sampler_i = 1'b0;
        rd_i_i        = 1'b0;
        rd_q_i        = 1'b0;
        repeat (16) @(posedge adc_clk);
        reset_i <= 1'b0;

        // zero phase, full rate passthrough
        configure(32'h0, 0, 0);
        read_pairs(100);
        // rotating phase over 320 samples
        configure(32'h0123_4567, 1, 0);
        read_pairs(160);
        configure(32'h0400_0000, 2, 1);
        read_pairs(40);
        configure(32'h00ff_0000, 0, 3);
        read_pairs(40);
        configure(32'h1000_0000, 4, 4);
        read_pairs(6);
        // restart in the middle of a running stream
        configure(32'h0a3d_70a4, 1, 1);
        read_pairs(30);
        restart_sampler();
        read_pairs(30);

        if (errors == 0)
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    end

endmodule

`default_nettype wire

/* tb.f */
rtl/wf_pkg.sv
rtl/wf_nco_mixer.sv
rtl/wf_cic_decim.sv
rtl/wf_sample_buf.sv
rtl/waterfall.sv
sim/waterfall_sva.sv
sim/tb_waterfall.sv

/* Bender.yml */
package:
  name: waterfall

sources:
  - rtl/wf_pkg.sv
  - rtl/wf_nco_mixer.sv
  - rtl/wf_cic_decim.sv
  - rtl/wf_sample_buf.sv
  - rtl/waterfall.sv
  - target: simulation
    files:
      - sim/waterfall_sva.sv
      - sim/tb_waterfall.sv
